/* compile.f */
logic/cache_pkg.sv
logic/word_path.sv
logic/set_lookup.sv
logic/miss_ctrl.sv
logic/main_mem.sv
logic/cache_top.sv
verif/tb_clock.sv
verif/cache_asserts.sv
verif/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

/* verif/tb_top.sv */
module tb_top;

	localparam int RESET_CYCLES = 8;
	localparam int N_ZERO_READS = 16;
	localparam int N_PAIRS      = 20;
	localparam int N_CONFLICT   = 1500;
	localparam int N_FRESH      = 16;
	localparam int N_FULL       = 500;
	localparam int N_OPS        = N_ZERO_READS + 2 * N_PAIRS + N_CONFLICT + N_FRESH + N_FULL;
	// worst miss is a dirty writeback plus a fetch
	localparam int TIMEOUT_CYCLES = N_OPS * (2 * cache_pkg::MEM_LATENCY + 4) + RESET_CYCLES;

	logic              clk;
	logic              rst;
	logic              i_rd;
	logic              i_wr;
	cache_pkg::addr_t  i_addr;
	cache_pkg::word_t  i_wdata;
	cache_pkg::word_t  o_rdata;
	logic              o_ready;

	// reference model, starts all zero like the backing memory
	bit [cache_pkg::WORD_W-1:0] model_mem [1 << cache_pkg::ADDR_W];
	// lines the processor has asked for at least once
	bit                         touched [cache_pkg::MEM_LINES];

	integer seed;
	int     cycle_cnt;

	tb_clock u_clock (
		.o_clk (clk)
	);

	cache_top dut (
		.clk     (clk),
		.rst     (rst),
		.i_rd    (i_rd),
		.i_wr    (i_wr),
		.i_addr  (i_addr),
		.i_wdata (i_wdata),
		.o_rdata (o_rdata),
		.o_ready (o_ready)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES));
		end
	end

	////////////////////////////////////////
	// processor access and model check
	////////////////////////////////////////
	// entered and left 1 unit after a rising edge; outputs sampled at the falling edge
	task automatic run_access(input logic rd, input logic wr, input cache_pkg::addr_t addr,
			input cache_pkg::word_t wdata, output cache_pkg::word_t rdata,
			output logic ready_first);
		i_rd    = rd;
		i_wr    = wr;
		i_addr  = addr;
		i_wdata = wdata;
		touched[addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W]] = 1'b1;
		@(negedge clk);
		ready_first = o_ready;
		while (!o_ready) begin
			@(negedge clk);
		end
		rdata = o_rdata;
		@(posedge clk);
		#1;
		i_rd = 1'b0;
		i_wr = 1'b0;
	endtask

	task automatic do_op(input logic rd, input logic wr, input cache_pkg::addr_t addr,
			input cache_pkg::word_t wdata, output logic ready_first);
		cache_pkg::word_t rdata;
		run_access(rd, wr, addr, wdata, rdata, ready_first);
		if (wr) begin
			model_mem[addr] = wdata;
		end
		if (rd) begin
			assert (rdata === model_mem[addr]) else begin
				abort_run($sformatf("mismatch at %0t: read of %h gave %h, expected %h",
					$time, addr, rdata, model_mem[addr]));
			end
		end
	endtask

	// conflict mode keeps to three tags over sets 3 and 17
	task automatic random_op(input bit conflict, output logic ready_first);
		logic [31:0]       r;
		logic [31:0]       r2;
		cache_pkg::tag_t   tag;
		cache_pkg::addr_t  addr;
		r  = $random(seed);
		r2 = $random(seed);
		case (r[7:0] % 8'd3)
			8'd0: tag = 9'h012;
			8'd1: tag = 9'h0a5;
			default: tag = 9'h1c3;
		endcase
		if (conflict) begin
			addr = {tag, (r[8] ? 5'd3 : 5'd17), r[10:9]};
		end else begin
			addr = r[31:16];
		end
		do_op(!r2[0], r2[0], addr, r2[31:16], ready_first);
	endtask

	task automatic pick_fresh(output cache_pkg::addr_t addr);
		logic [31:0] r;
		int          tries;
		tries = 0;
		r = $random(seed);
		while (touched[r[15:2]]) begin
			tries++;
			if (tries > 1000) begin
				abort_run("could not find a line that was never accessed");
			end
			r = $random(seed);
		end
		addr = r[15:0];
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		logic [31:0]       r;
		logic              rf;
		cache_pkg::addr_t  addr;
		seed       = 87;
		cycle_cnt  = 0;
		rst        = 1'b1;
		i_rd       = 1'b0;
		i_wr       = 1'b0;
		i_addr     = '0;
		i_wdata    = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		assert (o_ready === 1'b1) else begin
			abort_run($sformatf("mismatch at %0t: o_ready low while idle after reset", $time));
		end
		@(posedge clk);
		#1;

		// nothing written yet, so every read is zero
		for (int i = 0; i < N_ZERO_READS; i++) begin
			r = $random(seed);
			do_op(1'b1, 1'b0, r[15:0], '0, rf);
		end

		// read back right after the write completes
		for (int i = 0; i < N_PAIRS; i++) begin
			r    = $random(seed);
			addr = r[15:0];
			do_op(1'b0, 1'b1, addr, r[31:16], rf);
			do_op(1'b1, 1'b0, addr, '0, rf);
			assert (rf === 1'b1) else begin
				abort_run($sformatf("mismatch at %0t: read-back of %h stalled", $time, addr));
			end
		end

		// three tags in a 2-way set evict dirty lines
		for (int i = 0; i < N_CONFLICT; i++) begin
			random_op(1'b1, rf);
		end

		for (int i = 0; i < N_FRESH; i++) begin
			pick_fresh(addr);
			r = $random(seed);
			do_op(!r[0], r[0], addr, r[31:16], rf);
			assert (rf === 1'b0) else begin
				abort_run($sformatf("mismatch at %0t: first access to %h did not stall",
					$time, addr));
			end
		end

		for (int i = 0; i < N_FULL; i++) begin
			random_op(1'b0, rf);
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* verif/cache_asserts.sv */
module cache_asserts (
	input logic                   clk,
	input logic                   rst,
	input logic                   i_rd,
	input logic                   i_wr,
	input logic                   i_ready,
	input logic                   i_mem_req,
	input logic                   i_mem_we,
	input cache_pkg::line_addr_t  i_mem_addr,
	input cache_pkg::line_t       i_mem_wdata,
	input logic                   i_mem_done
);

	////////////////////////////////////////
	// memory handshake
	////////////////////////////////////////
	// fields hold while the memory is still busy
	req_stable: assert property (@(posedge clk) disable iff (rst)
		i_mem_req && !i_mem_done |=> i_mem_req && $stable(i_mem_we) &&
			$stable(i_mem_addr) && $stable(i_mem_wdata))
		else $error("memory request fields changed before done");

	// each request ends with done after the fixed latency
	done_latency: assert property (@(posedge clk) disable iff (rst)
		$rose(i_mem_req) |-> ##(cache_pkg::MEM_LATENCY - 1) i_mem_done)
		else $error("memory done missing at the fixed latency after a request");

	// one idle cycle between requests
	req_gap: assert property (@(posedge clk) disable iff (rst)
		i_mem_done |=> !i_mem_req)
		else $error("memory request still high right after done");

	////////////////////////////////////////
	// processor side
	////////////////////////////////////////
	ready_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(i_ready))
		else $error("ready is unknown after reset");

	one_cmd: assert property (@(posedge clk) disable iff (rst)
		!(i_rd && i_wr))
		else $error("read and write requested in the same cycle");

endmodule

bind cache_top cache_asserts u_asserts (
	.clk         (clk),
	.rst         (rst),
	.i_rd        (i_rd),
	.i_wr        (i_wr),
	.i_ready     (o_ready),
	.i_mem_req   (mem_req),
	.i_mem_we    (mem_we),
	.i_mem_addr  (mem_addr),
	.i_mem_wdata (mem_wdata),
	.i_mem_done  (mem_done)
);

/* verif/tb_clock.sv */
module tb_clock (
	output logic o_clk
);

	// period of 10, rising edges at 5, 15, 25 ...
	initial begin
		o_clk = 1'b0;
	end

	always begin
		#5;
		o_clk = ~o_clk;
	end

endmodule

/* logic/cache_top.sv */
module cache_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_rd,
	input  logic              i_wr,
	input  cache_pkg::addr_t  i_addr,
	input  cache_pkg::word_t  i_wdata,
	output cache_pkg::word_t  o_rdata,
	output logic              o_ready
);

	// lookup results
	logic              hit;
	logic              hit_way;
	cache_pkg::line_t  hit_line;
	logic              victim_way;
	logic              victim_valid;
	logic              victim_dirty;
	cache_pkg::tag_t   victim_tag;
	cache_pkg::line_t  victim_line;

	// array write controls
	logic              line_we;
	logic              line_way;
	logic              line_sel_fill;
	logic              set_dirty;
	logic              lru_we;
	cache_pkg::line_t  merged_line;
	cache_pkg::line_t  wr_line;

	// memory side
	logic                   mem_req;
	logic                   mem_we;
	cache_pkg::line_addr_t  mem_addr;
	cache_pkg::line_t       mem_wdata;
	logic                   mem_done;
	cache_pkg::line_t       mem_rdata;

	// fill line from memory, else the merged write line
	assign wr_line = line_sel_fill ? mem_rdata : merged_line;

	set_lookup u_lookup (
		.clk            (clk),
		.rst            (rst),
		.i_addr         (i_addr),
		.i_line_we      (line_we),
		.i_line_way     (line_way),
		.i_line         (wr_line),
		.i_set_dirty    (set_dirty),
		.i_lru_we       (lru_we),
		.o_hit          (hit),
		.o_hit_way      (hit_way),
		.o_hit_line     (hit_line),
		.o_victim_way   (victim_way),
		.o_victim_valid (victim_valid),
		.o_victim_dirty (victim_dirty),
		.o_victim_tag   (victim_tag),
		.o_victim_line  (victim_line)
	);

	miss_ctrl u_ctrl (
		.clk             (clk),
		.rst             (rst),
		.i_rd            (i_rd),
		.i_wr            (i_wr),
		.i_addr          (i_addr),
		.i_hit           (hit),
		.i_hit_way       (hit_way),
		.i_victim_way    (victim_way),
		.i_victim_valid  (victim_valid),
		.i_victim_dirty  (victim_dirty),
		.i_victim_tag    (victim_tag),
		.i_victim_line   (victim_line),
		.i_mem_done      (mem_done),
		.i_mem_rdata     (mem_rdata),
		.o_ready         (o_ready),
		.o_line_we       (line_we),
		.o_line_way      (line_way),
		.o_line_sel_fill (line_sel_fill),
		.o_set_dirty     (set_dirty),
		.o_lru_we        (lru_we),
		.o_mem_req       (mem_req),
		.o_mem_we        (mem_we),
		.o_mem_addr      (mem_addr),
		.o_mem_wdata     (mem_wdata)
	);

	word_path u_word (
		.i_offset (i_addr[cache_pkg::OFFSET_W-1:0]),
		.i_line   (hit_line),
		.i_wdata  (i_wdata),
		.o_rdata  (o_rdata),
		.o_merged (merged_line)
	);

	main_mem u_mem (
		.clk     (clk),
		.rst     (rst),
		.i_req   (mem_req),
		.i_we    (mem_we),
		.i_addr  (mem_addr),
		.i_wdata (mem_wdata),
		.o_done  (mem_done),
		.o_rdata (mem_rdata)
	);

endmodule

/* logic/main_mem.sv */
module main_mem (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_req,
	input  logic                   i_we,
	input  cache_pkg::line_addr_t  i_addr,
	input  cache_pkg::line_t       i_wdata,
	output logic                   o_done,
	output cache_pkg::line_t       o_rdata
);

	cache_pkg::line_t mem [cache_pkg::MEM_LINES];

	logic [cache_pkg::MEM_CNT_W-1:0] cnt;

	// backing store starts out all zero
	initial begin
		for (int i = 0; i < cache_pkg::MEM_LINES; i++) begin
			mem[i] = '0;
		end
	end

	////////////////////////////////////////
	// latency counter
	////////////////////////////////////////
	// done in the last cycle of the request window
	assign o_done = i_req && (cnt == cache_pkg::MEM_CNT_W'(cache_pkg::MEM_LATENCY - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (!i_req || o_done) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// line access
	////////////////////////////////////////
	assign o_rdata = mem[i_addr];

	// write lands on the done edge
	always @(posedge clk) begin
		if (o_done && i_we) begin
			mem[i_addr] <= i_wdata;
		end
	end

endmodule

/* logic/miss_ctrl.sv */
module miss_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   i_rd,
	input  logic                   i_wr,
	input  cache_pkg::addr_t       i_addr,
	input  logic                   i_hit,
	input  logic                   i_hit_way,
	input  logic                   i_victim_way,
	input  logic                   i_victim_valid,
	input  logic                   i_victim_dirty,
	input  cache_pkg::tag_t        i_victim_tag,
	input  cache_pkg::line_t       i_victim_line,
	input  logic                   i_mem_done,
	input  cache_pkg::line_t       i_mem_rdata,
	output logic                   o_ready,
	output logic                   o_line_we,
	output logic                   o_line_way,
	output logic                   o_line_sel_fill,
	output logic                   o_set_dirty,
	output logic                   o_lru_we,
	output logic                   o_mem_req,
	output logic                   o_mem_we,
	output cache_pkg::line_addr_t  o_mem_addr,
	output cache_pkg::line_t       o_mem_wdata
);

	cache_pkg::ctrl_state_t state;
	cache_pkg::ctrl_state_t next_state;

	logic              access;
	logic              req_q;
	cache_pkg::index_t idx;

	assign access = i_rd | i_wr;
	assign idx    = i_addr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];

	////////////////////////////////////////
	// state register
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cache_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	// req drops for a cycle after each done, then rises again while busy
	always_ff @(posedge clk) begin
		if (rst) begin
			req_q <= 1'b0;
		end else if (state == cache_pkg::IDLE) begin
			req_q <= access && !i_hit;
		end else if (i_mem_done) begin
			req_q <= 1'b0;
		end else begin
			req_q <= 1'b1;
		end
	end

	////////////////////////////////////////
	// next state and array controls
	////////////////////////////////////////
	always_comb begin
		next_state      = state;
		o_ready         = 1'b0;
		o_line_we       = 1'b0;
		o_line_way      = i_hit_way;
		o_line_sel_fill = 1'b0;
		o_set_dirty     = 1'b0;
		o_lru_we        = 1'b0;

		case (state)
			cache_pkg::IDLE: begin
				if (!access) begin
					o_ready = 1'b1;
				end else if (i_hit) begin
					o_ready  = 1'b1;
					o_lru_we = 1'b1;
					// write hit merges into the line and marks it dirty
					if (i_wr) begin
						o_line_we   = 1'b1;
						o_set_dirty = 1'b1;
					end
				end else if (i_victim_valid && i_victim_dirty) begin
					next_state = cache_pkg::WRITEBACK;
				end else begin
					next_state = cache_pkg::FETCH;
				end
			end
			cache_pkg::WRITEBACK: begin
				if (i_mem_done) begin
					next_state = cache_pkg::FETCH;
				end
			end
			cache_pkg::FETCH: begin
				// fetched line lands clean in the victim way
				if (i_mem_done) begin
					o_line_we       = 1'b1;
					o_line_way      = i_victim_way;
					o_line_sel_fill = 1'b1;
					next_state      = cache_pkg::IDLE;
				end
			end
			default: begin
				next_state = cache_pkg::IDLE;
			end
		endcase
	end

	////////////////////////////////////////
	// memory request fields
	////////////////////////////////////////
	assign o_mem_req   = req_q;
	assign o_mem_we    = (state == cache_pkg::WRITEBACK);
	assign o_mem_wdata = i_victim_line;
	assign o_mem_addr  = (state == cache_pkg::WRITEBACK) ? {i_victim_tag, idx} :
		i_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];

endmodule

/* logic/set_lookup.sv */
module set_lookup (
	input  logic              clk,
	input  logic              rst,
	input  cache_pkg::addr_t  i_addr,
	input  logic              i_line_we,
	input  logic              i_line_way,
	input  cache_pkg::line_t  i_line,
	input  logic              i_set_dirty,
	input  logic              i_lru_we,
	output logic              o_hit,
	output logic              o_hit_way,
	output cache_pkg::line_t  o_hit_line,
	output logic              o_victim_way,
	output logic              o_victim_valid,
	output logic              o_victim_dirty,
	output cache_pkg::tag_t   o_victim_tag,
	output cache_pkg::line_t  o_victim_line
);

	////////////////////////////////////////
	// storage
	////////////////////////////////////////
	cache_pkg::tag_t   tag_mem  [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
	cache_pkg::line_t  data_mem [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];

	logic [cache_pkg::NUM_SETS-1:0] valid_q [cache_pkg::NUM_WAYS];
	logic [cache_pkg::NUM_SETS-1:0] dirty_q [cache_pkg::NUM_WAYS];
	// lru bit names the way to replace next
	logic [cache_pkg::NUM_SETS-1:0] lru_q;

	cache_pkg::tag_t                addr_tag;
	cache_pkg::index_t              idx;
	logic [cache_pkg::NUM_WAYS-1:0] way_match;

	assign addr_tag = i_addr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W];
	assign idx      = i_addr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];

	////////////////////////////////////////
	// tag compare and victim choice
	////////////////////////////////////////
	always_comb begin
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			way_match[w] = valid_q[w][idx] && (tag_mem[w][idx] == addr_tag);
		end
	end

	assign o_hit      = |way_match;
	assign o_hit_way  = way_match[1];
	assign o_hit_line = data_mem[o_hit_way][idx];

	// an empty way wins over the lru choice
	always_comb begin
		if (!valid_q[0][idx]) begin
			o_victim_way = 1'b0;
		end else if (!valid_q[1][idx]) begin
			o_victim_way = 1'b1;
		end else begin
			o_victim_way = lru_q[idx];
		end
	end

	assign o_victim_valid = valid_q[o_victim_way][idx];
	assign o_victim_dirty = dirty_q[o_victim_way][idx];
	assign o_victim_tag   = tag_mem[o_victim_way][idx];
	assign o_victim_line  = data_mem[o_victim_way][idx];

	////////////////////////////////////////
	// array updates
	////////////////////////////////////////
	// tag always from the current address, both on fill and on write hit
	always_ff @(posedge clk) begin
		if (i_line_we) begin
			tag_mem[i_line_way][idx]  <= addr_tag;
			data_mem[i_line_way][idx] <= i_line;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			lru_q <= '0;
		end else begin
			if (i_line_we) begin
				valid_q[i_line_way][idx] <= 1'b1;
				dirty_q[i_line_way][idx] <= i_set_dirty;
			end
			// hit way becomes most recent, so the other one is next out
			if (i_lru_we) begin
				lru_q[idx] <= ~o_hit_way;
			end
		end
	end

endmodule

/* logic/word_path.sv */
module word_path (
	input  cache_pkg::offset_t  i_offset,
	input  cache_pkg::line_t    i_line,
	input  cache_pkg::word_t    i_wdata,
	output cache_pkg::word_t    o_rdata,
	output cache_pkg::line_t    o_merged
);

	cache_pkg::word_t words [cache_pkg::WORDS_PER_LINE];

	// split the line, word 0 from the low bits
	always_comb begin
		for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
			words[i] = i_line[i*cache_pkg::WORD_W +: cache_pkg::WORD_W];
		end
	end

	////////////////////////////////////////
	// read select
	////////////////////////////////////////
	assign o_rdata = words[i_offset];

	////////////////////////////////////////
	// write merge
	////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < cache_pkg::WORDS_PER_LINE; i++) begin
			if (cache_pkg::offset_t'(i) == i_offset) begin
				o_merged[i*cache_pkg::WORD_W +: cache_pkg::WORD_W] = i_wdata;
			end else begin
				o_merged[i*cache_pkg::WORD_W +: cache_pkg::WORD_W] = words[i];
			end
		end
	end

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////
	localparam int ADDR_W         = 16;
	localparam int WORD_W         = 16;
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
	localparam int OFFSET_W       = 2;
	localparam int INDEX_W        = 5;
	localparam int TAG_W          = 9;
	localparam int LINE_ADDR_W    = ADDR_W - OFFSET_W;

	// field positions inside a word address
	localparam int INDEX_LSB = OFFSET_W;
	localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

	////////////////////////////////////////
	// geometry and memory timing
	////////////////////////////////////////
	localparam int NUM_SETS    = 32;
	localparam int NUM_WAYS    = 2;
	localparam int MEM_LINES   = 1 << LINE_ADDR_W;
	localparam int MEM_LATENCY = 4;
	localparam int MEM_CNT_W   = 2;

	typedef logic [ADDR_W-1:0]      addr_t;
	typedef logic [WORD_W-1:0]      word_t;
	// word 0 in the low bits
	typedef logic [LINE_W-1:0]      line_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [TAG_W-1:0]       tag_t;
	typedef logic [INDEX_W-1:0]     index_t;
	typedef logic [OFFSET_W-1:0]    offset_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITEBACK,
		FETCH
	} ctrl_state_t;

endpackage
